/* hw/drop_cmd_decode.sv */
// --------------------------------------------------
// Turns command strobes into the registered per-port
// drop request mask that feeds the packet dropper
// --------------------------------------------------
`timescale 1ns/10ps

module drop_cmd_decode (
  input  logic                clk,
  input  logic                rst,
  input  logic                cmd_strobe,
  input  gate_pkg::drop_cmd_t cmd,
  output gate_pkg::port_mask_t drop_req
);

  // Mask with only the addressed port set
  gate_pkg::port_mask_t port_bit;

  assign port_bit = gate_pkg::port_mask_t'(1) << cmd.port;

  // The request is a level held here until another command changes it
  // A strobe at edge N is visible on drop_req right after that edge
  always_ff @(posedge clk) begin
    if (rst) begin
      drop_req <= '0;
    end else if (cmd_strobe) begin
      unique case (cmd.op)
        gate_pkg::drop_set: begin
          drop_req <= drop_req | port_bit;
        end
        gate_pkg::drop_clear: begin
          drop_req <= drop_req & ~port_bit;
        end
        gate_pkg::drop_set_all: begin
          drop_req <= '1;
        end
        gate_pkg::drop_clear_all: begin
          drop_req <= '0;
        end
      endcase
    end
  end

  // A strobed command must carry a defined opcode and port
  // Otherwise the request mask picks up X and poisons the dropper state
  a_cmd_known : assert property (
    @(posedge clk) disable iff (rst)
    cmd_strobe |-> !$isunknown(cmd)
  );

endmodule

/* hw/drop_stats.sv */
// --------------------------------------------------
// Counts dropped and forwarded packets per port and
// returns one counter per read strobe, one cycle later
// --------------------------------------------------
`timescale 1ns/10ps

module drop_stats (
  input  logic                clk,
  input  logic                rst,
  input  gate_pkg::pkt_end_t  pkt_end,
  input  logic                rd_strobe,
  input  stats_pkg::stat_req_t rd_req,
  output logic                rd_valid,
  output stats_pkg::stat_rsp_t rd_rsp
);

  // One pair of counters per port
  stats_pkg::count_t dropped_cnt   [gate_pkg::port_count];
  stats_pkg::count_t forwarded_cnt [gate_pkg::port_count];

  // Counter addressed by the current request
  stats_pkg::count_t sel_count;

  // Reads see the counter value from before this edge's increment
  assign sel_count = (rd_req.sel == stats_pkg::stat_dropped) ? dropped_cnt[rd_req.port]
                                                              : forwarded_cnt[rd_req.port];

  // Counters wrap and several ports may finish a packet in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < gate_pkg::port_count; i++) begin
        dropped_cnt[i]   <= '0;
        forwarded_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < gate_pkg::port_count; i++) begin
        if (pkt_end.done[i] && pkt_end.dropped[i]) begin
          dropped_cnt[i] <= dropped_cnt[i] + stats_pkg::count_t'(1);
        end
        if (pkt_end.done[i] && !pkt_end.dropped[i]) begin
          forwarded_cnt[i] <= forwarded_cnt[i] + stats_pkg::count_t'(1);
        end
      end
    end
  end

  // The answer flag is a one-cycle pulse behind the strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_strobe;
    end
  end

  // The answer stays on the port until the next read replaces it
  always_ff @(posedge clk) begin
    if (rd_strobe) begin
      rd_rsp.port  <= rd_req.port;
      rd_rsp.sel   <= rd_req.sel;
      rd_rsp.count <= sel_count;
    end
  end

  // A strobed read must name a defined port and counter
  // Otherwise the held answer turns to X until the next read
  a_req_known : assert property (
    @(posedge clk) disable iff (rst)
    rd_strobe |-> !$isunknown(rd_req)
  );

endmodule

/* hw/gate_pkg.sv */
// --------------------------------------------------
// Port-level types shared by the gate blocks: port masks,
// stream flag bundles and the drop command word
// --------------------------------------------------
package gate_pkg;

  // Number of stream ports handled by the gate
  parameter int port_count = 4;

  // One bit per stream port
  typedef logic [port_count-1:0] port_mask_t;

  // Number of a single port
  typedef logic [$clog2(port_count)-1:0] port_idx_t;

  // One direction of all four streams, valid and last side by side
  typedef struct packed {
    port_mask_t valid;
    port_mask_t last;
  } stream_flags_t;

  // Command opcodes for the drop request register
  typedef enum logic [1:0] {
    drop_set       = 2'd0,
    drop_clear     = 2'd1,
    drop_set_all   = 2'd2,
    drop_clear_all = 2'd3
  } drop_op_e;

  // A command names a port, which the all-port opcodes ignore
  typedef struct packed {
    drop_op_e  op;
    port_idx_t port;
  } drop_cmd_t;

  // Packet-end report, a dropped bit is only ever set together with its done bit
  typedef struct packed {
    port_mask_t done;
    port_mask_t dropped;
  } pkt_end_t;

endpackage

/* hw/packet_dropper.sv */
// --------------------------------------------------
// Gates valid and ready of four streams so that whole packets
// are dropped, and reports each packet end to the statistics
// --------------------------------------------------
`timescale 1ns/10ps

module packet_dropper #(
  parameter bit same_cycle_drop = 1'b0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  gate_pkg::port_mask_t    drop_req,
  input  gate_pkg::stream_flags_t s_flags,
  output gate_pkg::port_mask_t    s_ready,
  output gate_pkg::stream_flags_t m_flags,
  input  gate_pkg::port_mask_t    m_ready,
  output gate_pkg::pkt_end_t      pkt_end
);

  // Port is between packets after reset and after each last beat
  gate_pkg::port_mask_t sop;
  // Port is discarding the packet in flight
  gate_pkg::port_mask_t dropping;

  // Beat accepted on the upstream side
  gate_pkg::port_mask_t xfer;
  // Last beat of a packet accepted
  gate_pkg::port_mask_t end_beat;
  // Ports where a changed request may take effect this cycle
  gate_pkg::port_mask_t boundary;
  // Ports whose beats are swallowed this cycle
  gate_pkg::port_mask_t to_drop;

  assign xfer     = s_flags.valid & s_ready;
  assign end_beat = xfer & s_flags.last;

  // Without same-cycle dropping, a packet that starts in the same cycle
  // as the request still goes out, so only an idle start counts
  assign boundary = same_cycle_drop ? (sop | end_beat)
                                    : ((sop & ~s_flags.valid) | end_beat);

  // At start of packet the request can override the stored flag directly
  // and otherwise the flag alone decides until the packet ends
  assign to_drop = same_cycle_drop ? ((sop & drop_req) | (dropping & ~sop))
                                   : dropping;

  // Dropped beats are hidden downstream and acknowledged here
  // while last passes through untouched
  assign m_flags.valid = s_flags.valid & ~to_drop;
  assign m_flags.last  = s_flags.last;
  assign s_ready       = m_ready | to_drop;

  // Every finished packet is reported, with its fate
  assign pkt_end.done    = end_beat;
  assign pkt_end.dropped = end_beat & to_drop;

  always_ff @(posedge clk) begin
    if (rst) begin
      sop      <= '1;
      dropping <= '0;
    end else begin
      for (int i = 0; i < gate_pkg::port_count; i++) begin
        // A transfer leaves start-of-packet unless it was the last beat
        if (xfer[i]) begin
          sop[i] <= s_flags.last[i];
        end
        // The stored flag only follows the request at a boundary
        if (boundary[i]) begin
          dropping[i] <= drop_req[i];
        end
      end
    end
  end

  // A port that forwards a beat downstream passes back-pressure unchanged
  a_ready_follows : assert property (
    @(posedge clk) disable iff (rst)
    (m_flags.valid & (s_ready ^ m_ready)) == '0
  );

  // A packet keeps the fate its first beat got, so every later beat
  // is gated the same way as the one before it
  a_fate_held : assert property (
    @(posedge clk) disable iff (rst)
    ((to_drop ^ $past(to_drop)) & ~sop) == '0
  );

endmodule

/* hw/stats_pkg.sv */
// --------------------------------------------------
// Types for the packet statistics block and its read port
// --------------------------------------------------
package stats_pkg;

  // Packet counter, wraps on overflow
  typedef logic [31:0] count_t;

  // Picks which of the two per-port counters a read returns
  typedef enum logic {
    stat_dropped   = 1'b0,
    stat_forwarded = 1'b1
  } stat_sel_e;

  // Read request as presented with the read strobe
  typedef struct packed {
    gate_pkg::port_idx_t port;
    stat_sel_e           sel;
  } stat_req_t;

  // Read answer echoes the request so the caller can match it up
  typedef struct packed {
    gate_pkg::port_idx_t port;
    stat_sel_e           sel;
    count_t              count;
  } stat_rsp_t;

endpackage

/* hw/stream_gate_top.sv */
// --------------------------------------------------
// Packet gate for four streams: command decode, dropper
// and statistics wired together, set same_cycle_drop here
// --------------------------------------------------
`timescale 1ns/10ps

module stream_gate_top #(
  parameter bit same_cycle_drop = 1'b0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    cmd_strobe,
  input  gate_pkg::drop_cmd_t     cmd,
  input  gate_pkg::stream_flags_t s_flags,
  output gate_pkg::port_mask_t    s_ready,
  output gate_pkg::stream_flags_t m_flags,
  input  gate_pkg::port_mask_t    m_ready,
  input  logic                    rd_strobe,
  input  stats_pkg::stat_req_t    rd_req,
  output logic                    rd_valid,
  output stats_pkg::stat_rsp_t    rd_rsp
);

  // Registered drop level from the decoder
  gate_pkg::port_mask_t drop_req;
  // Packet-end report from the dropper
  gate_pkg::pkt_end_t   pkt_end;

  drop_cmd_decode decode0 (
    .clk        (clk),
    .rst        (rst),
    .cmd_strobe (cmd_strobe),
    .cmd        (cmd),
    .drop_req   (drop_req)
  );

  // Gating starts one cycle after a command, at the next packet boundary
  packet_dropper #(
    .same_cycle_drop (same_cycle_drop)
  ) dropper0 (
    .clk      (clk),
    .rst      (rst),
    .drop_req (drop_req),
    .s_flags  (s_flags),
    .s_ready  (s_ready),
    .m_flags  (m_flags),
    .m_ready  (m_ready),
    .pkt_end  (pkt_end)
  );

  drop_stats stats0 (
    .clk       (clk),
    .rst       (rst),
    .pkt_end   (pkt_end),
    .rd_strobe (rd_strobe),
    .rd_req    (rd_req),
    .rd_valid  (rd_valid),
    .rd_rsp    (rd_rsp)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the stream gate testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module stream_gate_tb \
  -f stream_gate.f \
  -o sim_stream_gate

./obj_dir/sim_stream_gate 2>&1 | tee sim.log

if grep -q "Finished with errors" sim.log; then
  echo "Simulation FAILED, see sim.log"
  exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
  echo "Simulation ended without a result, see sim.log"
  exit 1
fi
echo "Simulation PASSED"

/* stream_gate.f */
hw/gate_pkg.sv
hw/stats_pkg.sv
hw/drop_cmd_decode.sv
hw/packet_dropper.sv
hw/drop_stats.sv
hw/stream_gate_top.sv
test/stream_gate_tb.sv

/* test/stream_gate_stim.txt */
# In:  cmd_strobe cmd_op cmd_port s_valid s_last m_ready rd_strobe rd_port rd_sel
# Out: m_valid m_last s_ready rd_valid rsp_port rsp_sel rsp_count (masks hex, bit 0 is port 0)
# Forwarding after reset, back-pressure passes through
0 0 0 F 0 F 0 0 0  F 0 F 0 0 0 00000000
0 0 0 F F 5 0 0 0  F F 5 0 0 0 00000000
0 0 0 A A A 0 0 0  A A A 0 0 0 00000000
# Drop request on idle port 1 drops its next packet
1 0 1 0 0 0 0 0 0  0 0 0 0 0 0 00000000
0 0 0 F 0 0 0 0 0  D 0 2 0 0 0 00000000
0 0 0 F 2 0 0 0 0  D 2 2 0 0 0 00000000
# Request on port 0 in mid-packet waits for the packet end
1 0 0 1 0 1 0 0 0  1 0 3 0 0 0 00000000
0 0 0 1 0 1 0 0 0  1 0 3 0 0 0 00000000
0 0 0 1 1 1 0 0 0  1 1 3 0 0 0 00000000
0 0 0 1 1 0 0 0 0  0 1 3 0 0 0 00000000
# Clear on port 0 in a dropped packet takes effect after its last beat
1 1 0 1 0 1 0 0 0  0 0 3 0 0 0 00000000
0 0 0 1 0 0 0 0 0  0 0 3 0 0 0 00000000
0 0 0 1 1 0 0 0 0  0 1 3 0 0 0 00000000
0 0 0 1 1 1 0 0 0  1 1 3 0 0 0 00000000
# Set-all and clear-all act at each port's own boundary
1 2 0 C 0 C 0 0 0  C 0 E 0 0 0 00000000
0 0 0 F 0 F 0 0 0  C 0 F 0 0 0 00000000
0 0 0 F C F 0 0 0  C C F 0 0 0 00000000
1 3 0 F C 0 0 0 0  0 C F 0 0 0 00000000
0 0 0 F 3 0 0 0 0  C 3 3 0 0 0 00000000
0 0 0 F F F 0 0 0  F F F 0 0 0 00000000
# Counter reads, the answer arrives one cycle after the strobe
0 0 0 0 0 0 1 0 0  0 0 0 0 0 0 00000000
0 0 0 0 0 0 1 0 1  0 0 0 1 0 0 00000003
0 0 0 0 0 0 1 1 0  0 0 0 1 0 1 00000004
0 0 0 0 0 0 1 1 1  0 0 0 1 1 0 00000002
0 0 0 0 0 0 1 2 0  0 0 0 1 1 1 00000002
0 0 0 0 0 0 1 2 1  0 0 0 1 2 0 00000001
0 0 0 0 0 0 1 3 0  0 0 0 1 2 1 00000003
0 0 0 0 0 0 1 3 1  0 0 0 1 3 0 00000001
0 0 0 0 0 0 0 0 0  0 0 0 1 3 1 00000003
0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 00000000
# A read in the cycle of a packet end returns the count before it
0 0 0 1 1 1 1 0 1  1 1 1 0 0 0 00000000
0 0 0 0 0 0 1 0 1  0 0 0 1 0 1 00000004
0 0 0 0 0 0 0 0 0  0 0 0 1 0 1 00000005
0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 00000000

/* test/stream_gate_tb.sv */
// --------------------------------------------------
// Testbench for the stream gate that replays the vectors of the
// stim file on falling edges and checks the outputs per cycle
// --------------------------------------------------
`timescale 1ns/10ps

module stream_gate_tb;

  // One cycle of stimulus together with what the DUT must show in that cycle
  typedef struct packed {
    logic                    cmd_strobe;
    gate_pkg::drop_cmd_t     cmd;
    gate_pkg::stream_flags_t s_flags;
    gate_pkg::port_mask_t    m_ready;
    logic                    rd_strobe;
    stats_pkg::stat_req_t    rd_req;
    gate_pkg::stream_flags_t exp_m_flags;
    gate_pkg::port_mask_t    exp_s_ready;
    logic                    exp_rd_valid;
    stats_pkg::stat_rsp_t    exp_rd_rsp;
  } vector_t;

  localparam string stim_path  = "test/stream_gate_stim.txt";
  localparam int    clk_period = 100;

  logic                    clk;
  logic                    rst;
  logic                    cmd_strobe;
  gate_pkg::drop_cmd_t     cmd;
  gate_pkg::stream_flags_t s_flags;
  gate_pkg::port_mask_t    s_ready;
  gate_pkg::stream_flags_t m_flags;
  gate_pkg::port_mask_t    m_ready;
  logic                    rd_strobe;
  stats_pkg::stat_req_t    rd_req;
  logic                    rd_valid;
  stats_pkg::stat_rsp_t    rd_rsp;

  // All vectors are loaded before the first one is applied
  vector_t vectors[$];
  int      num_vec     = 0;
  int      error_count = 0;

  stream_gate_top #(
    .same_cycle_drop (1'b1)
  ) dut0 (
    .clk        (clk),
    .rst        (rst),
    .cmd_strobe (cmd_strobe),
    .cmd        (cmd),
    .s_flags    (s_flags),
    .s_ready    (s_ready),
    .m_flags    (m_flags),
    .m_ready    (m_ready),
    .rd_strobe  (rd_strobe),
    .rd_req     (rd_req),
    .rd_valid   (rd_valid),
    .rd_rsp     (rd_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Prints the reason, then the verdict, and ends the simulation
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_flags(input string name, input gate_pkg::stream_flags_t exp,
                             input gate_pkg::stream_flags_t act);
    if (act !== exp) begin
      error_count++;
      abort_run($sformatf("CHECK FAILED at %0t ns: %s expected %h, got %h",
                          $time, name, exp, act));
    end
  endtask

  task automatic check_mask(input string name, input gate_pkg::port_mask_t exp,
                            input gate_pkg::port_mask_t act);
    if (act !== exp) begin
      error_count++;
      abort_run($sformatf("CHECK FAILED at %0t ns: %s expected %h, got %h",
                          $time, name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      error_count++;
      abort_run($sformatf("CHECK FAILED at %0t ns: %s expected %b, got %b",
                          $time, name, exp, act));
    end
  endtask

  task automatic check_rsp(input string name, input stats_pkg::stat_rsp_t exp,
                           input stats_pkg::stat_rsp_t act);
    if (act !== exp) begin
      error_count++;
      abort_run($sformatf("CHECK FAILED at %0t ns: %s expected %h, got %h",
                          $time, name, exp, act));
    end
  endtask

  // Reads the stim file and skips lines that start with #
  task automatic load_vectors();
    int      fd;
    int      line_no;
    int      n;
    int      f[16];
    string   line;
    vector_t v;
    fd = $fopen(stim_path, "r");
    if (fd == 0) begin
      abort_run({"Cannot open the stimulus file ", stim_path});
    end
    line_no = 0;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      line_no++;
      if (line.len() == 0 || line[0] == "#") continue;
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                  f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
      // Blank lines carry no vector
      if (n <= 0) continue;
      if (n != 16) begin
        abort_run($sformatf("Stimulus line %0d holds %0d of 16 fields", line_no, n));
      end
      v.cmd_strobe       = (f[0] != 0);
      v.cmd.op           = gate_pkg::drop_op_e'(f[1][1:0]);
      v.cmd.port         = gate_pkg::port_idx_t'(f[2]);
      v.s_flags.valid    = gate_pkg::port_mask_t'(f[3]);
      v.s_flags.last     = gate_pkg::port_mask_t'(f[4]);
      v.m_ready          = gate_pkg::port_mask_t'(f[5]);
      v.rd_strobe        = (f[6] != 0);
      v.rd_req.port      = gate_pkg::port_idx_t'(f[7]);
      v.rd_req.sel       = stats_pkg::stat_sel_e'(f[8][0]);
      v.exp_m_flags.valid = gate_pkg::port_mask_t'(f[9]);
      v.exp_m_flags.last  = gate_pkg::port_mask_t'(f[10]);
      v.exp_s_ready      = gate_pkg::port_mask_t'(f[11]);
      v.exp_rd_valid     = (f[12] != 0);
      v.exp_rd_rsp.port  = gate_pkg::port_idx_t'(f[13]);
      v.exp_rd_rsp.sel   = stats_pkg::stat_sel_e'(f[14][0]);
      v.exp_rd_rsp.count = stats_pkg::count_t'(f[15]);
      vectors.push_back(v);
    end
    $fclose(fd);
    if (vectors.size() == 0) begin
      abort_run({"The stimulus file holds no vectors: ", stim_path});
    end
    num_vec = vectors.size();
  endtask

  task automatic drive_vector(input vector_t v);
    cmd_strobe = v.cmd_strobe;
    cmd        = v.cmd;
    s_flags    = v.s_flags;
    m_ready    = v.m_ready;
    rd_strobe  = v.rd_strobe;
    rd_req     = v.rd_req;
  endtask

  // The answer word is compared in the cycles where rd_valid is expected
  task automatic compare_outputs(input vector_t v);
    check_flags("m_flags", v.exp_m_flags, m_flags);
    check_mask("s_ready", v.exp_s_ready, s_ready);
    check_bit("rd_valid", v.exp_rd_valid, rd_valid);
    if (v.exp_rd_valid) begin
      check_rsp("rd_rsp", v.exp_rd_rsp, rd_rsp);
    end
  endtask

  initial begin
    rst        = 1'b1;
    cmd_strobe = 1'b0;
    cmd        = '0;
    s_flags    = '0;
    m_ready    = '0;
    rd_strobe  = 1'b0;
    rd_req     = '0;
    load_vectors();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // Outputs are sampled 10 ns before the rising edge that ends the cycle
    for (int i = 0; i < num_vec; i++) begin
      if (i > 0) @(negedge clk);
      drive_vector(vectors[i]);
      #(clk_period / 2 - 10);
      compare_outputs(vectors[i]);
    end
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Allows the reset cycles plus a margin beyond one clock per vector
  initial begin
    wait (num_vec > 0);
    #((num_vec + 20) * clk_period);
    abort_run("Timeout: the vectors did not complete in the expected time");
  end

endmodule
